/* sources.f */
common/fetch_pkg.sv
l1i/l1i_cache.sv
l1i/l1i_refill.sv
hw/fetch_sequencer.sv
hw/fetch_unit.sv
bench/fetch_mem_model.sv
bench/fetch_unit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fetch unit testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module fetch_unit_tb -f sources.f \
  && ./obj_dir/Vfetch_unit_tb \
  || { echo "build or simulation failed"; exit 1; }

/* bench/fetch_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb;
  import fetch_pkg::*;

  localparam int SETS_LOG2 = 2;
  localparam int SETS      = 1 << SETS_LOG2;
  localparam int TIMEOUT   = 4000;  // roughly four times the expected run

  logic clk, rst;
  logic [ADDR_W-1:0] araddr_o, pc_o, npc_i;
  logic [DATA_W-1:0] rdata_i, inst_o, chk_word;
  logic arvalid_o, busy_o, rvalid_i, valid_o, ready_o;
  logic next_ready_i, prev_valid_i, pc_valid_i, pc_skip_i;

  logic [31:0]       lfsr;
  logic [ADDR_W-1:0] exp_pc, cur_target, hold_pc, line_addr;
  logic [DATA_W-1:0] hold_inst;
  logic [ADDR_W-1:0] targets [$];
  logic              waiting, skip_pending, skip_done, need_miss, done;
  logic              hold_prev, arv_prev, beat_idx;
  int                wait_cnt, cycles;
  logic              shadow_v [SETS];
  logic [ADDR_W-4:0] shadow_line [SETS];

  fetch_unit #(.SETS_LOG2(SETS_LOG2)) fetch_unit_i (
    .clk(clk), .rst(rst),
    .araddr_o(araddr_o), .arvalid_o(arvalid_o), .busy_o(busy_o),
    .rdata_i(rdata_i), .rvalid_i(rvalid_i),
    .inst_o(inst_o), .pc_o(pc_o), .valid_o(valid_o), .ready_o(ready_o),
    .next_ready_i(next_ready_i), .prev_valid_i(prev_valid_i),
    .pc_valid_i(pc_valid_i), .pc_skip_i(pc_skip_i), .npc_i(npc_i)
  );

  fetch_mem_model mem_i (
    .clk(clk), .rst(rst), .araddr_i(araddr_o), .arvalid_i(arvalid_o),
    .chk_addr_i(pc_o), .rvalid_o(rvalid_i), .rdata_o(rdata_i), .chk_word_o(chk_word)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h8020_0003;
    return n;
  endfunction

  function automatic int set_of(input logic [ADDR_W-1:0] a);
    return int'(a[SETS_LOG2+2:3]);
  endfunction

  task automatic require(input logic ok, input string what);
    assert (ok) else begin
      $display("** Error at %0t ns: %s", $time, what);
      $display("=== FAIL ===");
      $fatal(1, "check failed");
    end
  endtask

  // everything sampled here belongs to the cycle that just ended
  task automatic observe_cycle();
    logic handoff;
    logic redirect;
    logic is_ctrl;
    handoff  = valid_o && next_ready_i;
    redirect = prev_valid_i && (pc_valid_i || pc_skip_i);
    require(ready_o == !valid_o, "ready_o is not the inverse of valid_o");
    if (hold_prev) begin
      require(valid_o && pc_o == hold_pc && inst_o == hold_inst,
              $sformatf("output moved under back-pressure, pc %h", pc_o));
      require(!(arvalid_o && !arv_prev), "bus request raised under back-pressure");
    end
    if (arvalid_o && !arv_prev) begin
      require(araddr_o[1:0] == 2'b00, $sformatf("unaligned request %h", araddr_o));
      if (!beat_idx) begin
        require(!araddr_o[2], $sformatf("first beat not word 0: %h", araddr_o));
        require(!(shadow_v[set_of(araddr_o)] &&
                  shadow_line[set_of(araddr_o)] == araddr_o[ADDR_W-1:3]),
                $sformatf("refill of a cached line %h", araddr_o));
        line_addr = araddr_o;
        need_miss = 1'b0;
      end else begin
        require(araddr_o == line_addr + 32'd4,
                $sformatf("second beat %h, line %h", araddr_o, line_addr));
      end
      beat_idx = !beat_idx;
    end
    if (rvalid_i) begin
      shadow_v[set_of(araddr_o)] = araddr_o[2];  // word 0 drops the old line
      shadow_line[set_of(araddr_o)] = araddr_o[ADDR_W-1:3];
    end
    if (handoff) begin
      require(!waiting, $sformatf("handoff at %h before next pc was given", pc_o));
      require(pc_o == exp_pc, $sformatf("pc %h, expected %h", pc_o, exp_pc));
      require(inst_o == chk_word, $sformatf("inst %h at %h, expected %h",
                                            inst_o, pc_o, chk_word));
      require(!need_miss, "no refill after fence.i");
      is_ctrl = inst_o[6:0] == OP_JAL || inst_o[6:0] == OP_JALR ||
                inst_o[6:0] == OP_BRANCH || inst_o[6:0] == OP_SYSTEM;
      if (is_ctrl) begin
        waiting  = 1'b1;
        wait_cnt = 2;
        if (targets.size() == 0) done = 1'b1;
        else cur_target = targets.pop_front();
      end else begin
        exp_pc = exp_pc + 32'd4;
      end
      if (inst_o == INST_FENCE_I) begin
        need_miss = 1'b1;
        for (int s = 0; s < SETS; s++) shadow_v[s] = 1'b0;
      end
      if (pc_o == PC_INIT + 32'h74 && !skip_done) skip_pending = 1'b1;
    end
    if (redirect) begin
      exp_pc  = npc_i;
      waiting = 1'b0;
    end
    hold_prev = valid_o && !next_ready_i && !redirect;
    hold_pc   = pc_o;
    hold_inst = inst_o;
    arv_prev  = arvalid_o;
  endtask

  task automatic drive_inputs();
    prev_valid_i = 1'b0;
    pc_valid_i   = 1'b0;
    pc_skip_i    = 1'b0;
    if (skip_pending) begin
      next_ready_i = 1'b0;  // hold pc until the line is in and the bus is quiet
      if (!busy_o && !arvalid_o) begin
        prev_valid_i = 1'b1;
        pc_skip_i    = 1'b1;
        npc_i        = PC_INIT + 32'h40;
        skip_pending = 1'b0;
        skip_done    = 1'b1;
      end
    end else begin
      next_ready_i = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    if (waiting) begin
      if (wait_cnt > 0) begin
        wait_cnt = wait_cnt - 1;
      end else begin
        prev_valid_i = 1'b1;
        pc_valid_i   = 1'b1;
        npc_i        = cur_target;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the test did not finish within %0d cycles", TIMEOUT);
      $display("=== FAIL ===");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst = 1'b1;
    next_ready_i = 1'b0;
    prev_valid_i = 1'b0;
    pc_valid_i = 1'b0;
    pc_skip_i = 1'b0;
    npc_i = '0;
    cycles = 0;
    lfsr = 32'h456e_7bb6;
    exp_pc = PC_INIT;
    cur_target = '0;
    line_addr = '0;
    hold_pc = '0;
    hold_inst = '0;
    {waiting, skip_pending, skip_done, need_miss, done} = '0;
    {hold_prev, arv_prev, beat_idx} = '0;
    wait_cnt = 0;
    for (int s = 0; s < SETS; s++) begin
      shadow_v[s] = 1'b0;
      shadow_line[s] = '0;
    end
    // back to a cached line, past the jump, past the branch, then a fresh region
    targets = {PC_INIT, PC_INIT + 32'h24, PC_INIT + 32'h38, PC_INIT + 32'h60};
    repeat (16) @(posedge clk);
    require(!valid_o && !busy_o && !arvalid_o && pc_o == PC_INIT,
            "wrong state under reset");
    #1 rst = 1'b0;
    while (!done) begin
      @(posedge clk);
      observe_cycle();
      if (!done) begin
        #1;
        drive_inputs();
      end
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/fetch_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_mem_model (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic [fetch_pkg::ADDR_W-1:0] araddr_i,
  input  wire logic                         arvalid_i,
  input  wire logic [fetch_pkg::ADDR_W-1:0] chk_addr_i,
  output logic                              rvalid_o,
  output logic [fetch_pkg::DATA_W-1:0]      rdata_o,
  output logic [fetch_pkg::DATA_W-1:0]      chk_word_o
);
  import fetch_pkg::*;

  logic [31:0]       lfsr;
  logic              pending;
  int                cnt;
  logic [ADDR_W-1:0] req_addr;
  logic              rst_s;
  logic              arv_s;
  logic [ADDR_W-1:0] addr_s;
  logic              b0;
  logic              b1;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    return n;
  endfunction

  // program image: addi x1, x0, A[13:2] except a few control words
  function automatic logic [DATA_W-1:0] image_word(input logic [ADDR_W-1:0] a);
    case (a)
      PC_INIT + 32'h14: return {25'h0000_100, OP_JAL};
      PC_INIT + 32'h34: return {25'h0000_008, OP_BRANCH};
      PC_INIT + 32'h40: return INST_FENCE_I;
      PC_INIT + 32'h50: return {25'h0, OP_SYSTEM};
      default:          return {a[13:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
    endcase
  endfunction

  always_comb chk_word_o = image_word(chk_addr_i);

  initial begin
    rvalid_o = 1'b0;
    rdata_o  = '0;
    pending  = 1'b0;
    cnt      = 0;
    req_addr = '0;
    lfsr     = 32'h456e_7bb6;
    forever begin
      @(posedge clk);
      rst_s  = rst;
      arv_s  = arvalid_i;
      addr_s = araddr_i;
      #1;
      if (rst_s) begin
        rvalid_o = 1'b0;
        pending  = 1'b0;
      end else if (rvalid_o) begin
        rvalid_o = 1'b0;  // request still high on this edge, ignore it
      end else if (pending) begin
        if (cnt == 1) begin
          rvalid_o = 1'b1;
          rdata_o  = image_word(req_addr);
          pending  = 1'b0;
        end else begin
          cnt = cnt - 1;
        end
      end else if (arv_s) begin
        b0 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b1 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        pending  = 1'b1;
        req_addr = addr_s;
        cnt      = 1 + int'({b1, b0});  // 1 to 4 cycles
      end
    end
  end

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter int SETS_LOG2 = 2
) (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // read bus
  output logic [fetch_pkg::ADDR_W-1:0]     araddr_o,
  output logic                             arvalid_o,
  output logic                             busy_o,
  input  wire logic [fetch_pkg::DATA_W-1:0] rdata_i,
  input  wire logic                        rvalid_i,
  // decode side
  output logic [fetch_pkg::DATA_W-1:0]     inst_o,
  output logic [fetch_pkg::ADDR_W-1:0]     pc_o,
  output logic                             valid_o,
  output logic                             ready_o,
  input  wire logic                        next_ready_i,
  // redirect from the back end
  input  wire logic                        prev_valid_i,
  input  wire logic                        pc_valid_i,
  input  wire logic                        pc_skip_i,
  input  wire logic [fetch_pkg::ADDR_W-1:0] npc_i
);
  import fetch_pkg::*;

  localparam int WORDS_LOG2 = 1;  // two-word lines

  logic                  wr_en;
  logic [WORDS_LOG2-1:0] wr_word;
  logic [DATA_W-1:0]     wr_data;
  logic                  wr_tag_valid;
  logic                  hit;
  logic [DATA_W-1:0]     hit_data;
  logic                  fwd_valid;
  logic [DATA_W-1:0]     fwd_data;
  logic                  flush;
  logic                  stall;

  l1i_cache #(
    .SETS_LOG2 (SETS_LOG2),
    .WORDS_LOG2(WORDS_LOG2)
  ) cache_i (
    .clk           (clk),
    .rst           (rst),
    .pc_i          (pc_o),
    .wr_en_i       (wr_en),
    .wr_word_i     (wr_word),
    .wr_data_i     (wr_data),
    .wr_tag_valid_i(wr_tag_valid),
    .flush_i       (flush),
    .hit_o         (hit),
    .hit_data_o    (hit_data)
  );

  l1i_refill #(
    .SETS_LOG2 (SETS_LOG2),
    .WORDS_LOG2(WORDS_LOG2)
  ) refill_i (
    .clk           (clk),
    .rst           (rst),
    .pc_i          (pc_o),
    .hit_i         (hit),
    .stall_i       (stall),
    .rvalid_i      (rvalid_i),
    .rdata_i       (rdata_i),
    .araddr_o      (araddr_o),
    .arvalid_o     (arvalid_o),
    .busy_o        (busy_o),
    .wr_en_o       (wr_en),
    .wr_word_o     (wr_word),
    .wr_data_o     (wr_data),
    .wr_tag_valid_o(wr_tag_valid),
    .fwd_valid_o   (fwd_valid),
    .fwd_data_o    (fwd_data)
  );

  fetch_sequencer seq_i (
    .clk         (clk),
    .rst         (rst),
    .hit_i       (hit),
    .hit_data_i  (hit_data),
    .fwd_valid_i (fwd_valid),
    .fwd_data_i  (fwd_data),
    .next_ready_i(next_ready_i),
    .prev_valid_i(prev_valid_i),
    .pc_valid_i  (pc_valid_i),
    .pc_skip_i   (pc_skip_i),
    .npc_i       (npc_i),
    .pc_o        (pc_o),
    .inst_o      (inst_o),
    .valid_o     (valid_o),
    .ready_o     (ready_o),
    .flush_o     (flush),
    .stall_o     (stall)
  );

endmodule

`default_nettype wire

/* hw/fetch_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        hit_i,
  input  wire logic [fetch_pkg::DATA_W-1:0] hit_data_i,
  input  wire logic                        fwd_valid_i,
  input  wire logic [fetch_pkg::DATA_W-1:0] fwd_data_i,
  input  wire logic                        next_ready_i,
  input  wire logic                        prev_valid_i,
  input  wire logic                        pc_valid_i,
  input  wire logic                        pc_skip_i,
  input  wire logic [fetch_pkg::ADDR_W-1:0] npc_i,
  output logic [fetch_pkg::ADDR_W-1:0]     pc_o,
  output logic [fetch_pkg::DATA_W-1:0]     inst_o,
  output logic                             valid_o,
  output logic                             ready_o,
  output logic                             flush_o,
  output logic                             stall_o
);
  import fetch_pkg::*;

  seq_state_e state_q, state_d;

  logic [ADDR_W-1:0] pc_q, pc_d;
  opcode_e           opcode;
  logic              is_ctrl;
  logic              handoff;
  logic              redirect;

  // the forwarded beat only exists while the line is not yet valid
  assign inst_o  = fwd_valid_i ? fwd_data_i : hit_data_i;
  assign valid_o = (fwd_valid_i || hit_i) && (state_q == SEQ_RUN);
  assign ready_o = !valid_o;
  assign pc_o    = pc_q;

  assign opcode  = opcode_e'(inst_o[6:0]);
  assign is_ctrl = (opcode == OP_JAL) || (opcode == OP_JALR) ||
                   (opcode == OP_BRANCH) || (opcode == OP_SYSTEM);

  assign handoff = valid_o && next_ready_i;

  // resolved target after a hazard, or a skip from the back end at any time
  assign redirect = prev_valid_i &&
                    ((state_q == SEQ_HAZARD && pc_valid_i) || pc_skip_i);

  assign flush_o = handoff && (inst_o == INST_FENCE_I);
  assign stall_o = state_q == SEQ_HAZARD;  // keeps the refill engine quiet

  always_comb begin
    pc_d    = pc_q;
    state_d = state_q;
    if (redirect) begin
      pc_d    = npc_i;
      state_d = SEQ_RUN;
    end else if (handoff) begin
      if (is_ctrl) begin
        state_d = SEQ_HAZARD;  // wait for the core to supply npc
      end else begin
        pc_d = pc_q + ADDR_W'(4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= PC_INIT;
      state_q <= SEQ_RUN;
    end else begin
      pc_q    <= pc_d;
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

/* l1i/l1i_refill.sv */
`timescale 1ns/1ps
`default_nettype none

module l1i_refill #(
  parameter int SETS_LOG2  = 2,
  parameter int WORDS_LOG2 = 1
) (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic [fetch_pkg::ADDR_W-1:0] pc_i,
  input  wire logic                        hit_i,
  input  wire logic                        stall_i,
  input  wire logic                        rvalid_i,
  input  wire logic [fetch_pkg::DATA_W-1:0] rdata_i,
  output logic [fetch_pkg::ADDR_W-1:0]     araddr_o,
  output logic                             arvalid_o,
  output logic                             busy_o,
  output logic                             wr_en_o,
  output logic [WORDS_LOG2-1:0]            wr_word_o,
  output logic [fetch_pkg::DATA_W-1:0]     wr_data_o,
  output logic                             wr_tag_valid_o,
  output logic                             fwd_valid_o,
  output logic [fetch_pkg::DATA_W-1:0]     fwd_data_o
);
  import fetch_pkg::*;

  localparam int IDX_LSB = WORDS_LOG2 + 2;
  localparam int TAG_LSB = SETS_LOG2 + WORDS_LOG2 + 2;
  localparam int TAG_W   = ADDR_W - TAG_LSB;

  refill_state_e state_q, state_d;

  logic [TAG_W-1:0]     tag_q;  // line under refill
  logic [SETS_LOG2-1:0] idx_q;
  logic                 line_match;
  logic                 second_beat;
  logic                 beat;

  // a redirect mid-refill must not land beats in the wrong set
  assign line_match  = {pc_i[ADDR_W-1:TAG_LSB], pc_i[TAG_LSB-1:IDX_LSB]} == {tag_q, idx_q};
  assign second_beat = (state_q == RF_WORD1) || (state_q == RF_DONE);
  assign beat        = rvalid_i && ((state_q == RF_WORD0) || (state_q == RF_WORD1));

  always_comb begin
    araddr_o = {tag_q, idx_q, WORDS_LOG2'(second_beat), 2'b00};
    if (state_q == RF_IDLE) begin
      araddr_o = {pc_i[ADDR_W-1:IDX_LSB], {WORDS_LOG2{1'b0}}, 2'b00};
    end
  end

  // no request while reset is held
  assign arvalid_o = (state_q == RF_IDLE) ? (!hit_i && !stall_i && !rst) :
                     (state_q == RF_WORD0) || (state_q == RF_WORD1);
  assign busy_o    = state_q != RF_IDLE;

  assign wr_en_o        = beat && line_match;
  assign wr_word_o      = WORDS_LOG2'(state_q == RF_WORD1);
  assign wr_data_o      = rdata_i;
  assign wr_tag_valid_o = state_q == RF_WORD1;

  // odd-word pc gets its instruction straight off the bus
  assign fwd_valid_o = (state_q == RF_WORD1) && rvalid_i && line_match &&
                       (&pc_i[IDX_LSB-1:2]);
  assign fwd_data_o  = rdata_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RF_IDLE:  if (arvalid_o) state_d = RF_WORD0;
      RF_WORD0: if (rvalid_i) state_d = RF_GAP;
      RF_GAP:   state_d = RF_WORD1;
      RF_WORD1: if (rvalid_i) state_d = RF_DONE;
      RF_DONE:  state_d = RF_IDLE;
      default:  state_d = RF_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == RF_IDLE) begin
      tag_q <= pc_i[ADDR_W-1:TAG_LSB];
      idx_q <= pc_i[TAG_LSB-1:IDX_LSB];
    end
  end

endmodule

`default_nettype wire

/* l1i/l1i_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module l1i_cache #(
  parameter int SETS_LOG2  = 2,
  parameter int WORDS_LOG2 = 1
) (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic [fetch_pkg::ADDR_W-1:0] pc_i,
  input  wire logic                        wr_en_i,
  input  wire logic [WORDS_LOG2-1:0]       wr_word_i,
  input  wire logic [fetch_pkg::DATA_W-1:0] wr_data_i,
  input  wire logic                        wr_tag_valid_i,
  input  wire logic                        flush_i,
  output logic                             hit_o,
  output logic [fetch_pkg::DATA_W-1:0]     hit_data_o
);
  import fetch_pkg::*;

  localparam int SETS    = 1 << SETS_LOG2;
  localparam int WORDS   = 1 << WORDS_LOG2;
  localparam int IDX_LSB = WORDS_LOG2 + 2;
  localparam int TAG_LSB = SETS_LOG2 + WORDS_LOG2 + 2;
  localparam int TAG_W   = ADDR_W - TAG_LSB;

  logic [DATA_W-1:0] data_q [SETS][WORDS];
  logic [TAG_W-1:0]  tag_q  [SETS];
  logic [SETS-1:0]   valid_q;

  logic [TAG_W-1:0]      pc_tag;
  logic [SETS_LOG2-1:0]  pc_idx;
  logic [WORDS_LOG2-1:0] pc_word;

  assign pc_tag  = pc_i[ADDR_W-1:TAG_LSB];
  assign pc_idx  = pc_i[TAG_LSB-1:IDX_LSB];
  assign pc_word = pc_i[IDX_LSB-1:2];

  assign hit_o      = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign hit_data_o = data_q[pc_idx][pc_word];

  // line payload, written beat by beat during refill
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      data_q[pc_idx][wr_word_i] <= wr_data_i;
      if (wr_tag_valid_i) begin
        tag_q[pc_idx] <= pc_tag;
      end
    end
  end

  // first beat drops the old line, last beat makes the new one valid
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;  // fence.i wins over a same-cycle line fill
    end else if (wr_en_i) begin
      valid_q[pc_idx] <= wr_tag_valid_i;
    end
  end

endmodule

`default_nettype wire

/* common/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  localparam logic [ADDR_W-1:0] PC_INIT = 32'h8000_0000;

  // fence.i: funct3=001, opcode MISC-MEM
  localparam logic [DATA_W-1:0] INST_FENCE_I = 32'h0000_100f;

  // major opcodes that the predecoder cares about
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    RF_IDLE  = 3'd0,
    RF_WORD0 = 3'd1,
    RF_GAP   = 3'd2,  // turnaround between the two reads
    RF_WORD1 = 3'd3,
    RF_DONE  = 3'd4
  } refill_state_e;

  typedef enum logic {
    SEQ_RUN    = 1'b0,
    SEQ_HAZARD = 1'b1
  } seq_state_e;

endpackage

`default_nettype wire
